// File: bench/tb_rvseed.sv
`timescale 1ns/1ps

module tb_rvseed import rvseed_pkg::*; ();

    localparam int IMEM_WORDS = 64;
    localparam int AW         = $clog2(IMEM_WORDS);
    localparam int CLK_PERIOD = 10;
    localparam int MAX_CYCLES = 20000;  // all status polls plus apb traffic, with margin
    localparam int MAX_POLLS  = 200;
    localparam int MAX_STEPS  = 2000;
    localparam logic [31:0] EBREAK_WORD  = 32'h0010_0073;
    localparam logic [31:0] ILLEGAL_WORD = 32'h0000_0003;  // load opcode, unsupported

    logic        clk;
    logic        rst;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          seed = 41671;
    int          cycle_count = 0;
    int          error_count = 0;
    logic [31:0] prog [IMEM_WORDS];
    int          prog_len;
    logic [63:0] mregs [32];  // reference model state
    logic [63:0] mpc;
    logic        mdone;
    logic        millegal;

    rvseed_top #(.IMEM_WORDS(IMEM_WORDS)) rvseed_top_inst (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("simulation timed out after %0d cycles", cycle_count);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    // instruction encoders
    function automatic logic [31:0] r_word(input logic [6:0] f7, input int rd, rs1, rs2);
        return {f7, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'h33};
    endfunction

    function automatic logic [31:0] i_word(input logic [6:0] op, input int rd, rs1, imm);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), op};  // addi and jalr share funct3 0
    endfunction

    function automatic logic [31:0] u_word(input logic [6:0] op, input int rd, imm20);
        return {20'(imm20), 5'(rd), op};
    endfunction

    function automatic logic [31:0] bne_word(input int rs1, rs2, off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'b001, o[4:1], o[11], 7'h63};
    endfunction

    function automatic logic [31:0] jal_word(input int rd, off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'h6f};
    endfunction

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(negedge clk);
        paddr   = addr;
        pwdata  = wdata;
        pwrite  = wr;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;  // outputs settled, well before the completing edge
        check("pready", 64'(pready), 64'd1);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused_rdata;
        apb_transfer(1'b1, addr, data, unused_rdata, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        apb_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic write_ok(input logic [11:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check("pslverr", 64'(err), 64'd0);
    endtask

    task automatic read_ok(input logic [11:0] addr, output logic [31:0] data);
        logic err;
        apb_read(addr, data, err);
        check("pslverr", 64'(err), 64'd0);
    endtask

    task automatic append_word(input logic [31:0] w);
        prog[AW'(prog_len)] = w;
        prog_len++;
    endtask

    // ISA level model, runs prog until ebreak or an illegal word
    task automatic model_run();
        logic [31:0] inst;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] next_pc;
        logic [63:0] wval;
        logic        wr;
        int          steps;
        mpc      = '0;
        mdone    = 1'b0;
        millegal = 1'b0;
        steps    = 0;
        while (!mdone && !millegal && steps < MAX_STEPS) begin
            inst    = prog[mpc[AW+1:2]];
            a       = mregs[inst[19:15]];
            b       = mregs[inst[24:20]];
            next_pc = mpc + 64'd4;
            wr      = 1'b0;
            wval    = '0;
            case (inst[6:0])
                7'h33: begin  // add, sub
                    wr = 1'b1;
                    if (inst[14:12] != 3'b000) millegal = 1'b1;
                    else if (inst[31:25] == 7'h00) wval = a + b;
                    else if (inst[31:25] == 7'h20) wval = a - b;
                    else millegal = 1'b1;
                end
                7'h13: begin
                    wr   = 1'b1;
                    wval = a + 64'($signed(inst[31:20]));
                    if (inst[14:12] != 3'b000) millegal = 1'b1;
                end
                7'h63: begin
                    if (inst[14:12] != 3'b001) millegal = 1'b1;
                    else if (a != b) next_pc = mpc + 64'($signed({inst[31], inst[7],
                        inst[30:25], inst[11:8], 1'b0}));
                end
                7'h6f: begin
                    wr      = 1'b1;
                    wval    = mpc + 64'd4;
                    next_pc = mpc + 64'($signed({inst[31], inst[19:12], inst[20],
                        inst[30:21], 1'b0}));
                end
                7'h67: begin
                    wr      = 1'b1;
                    wval    = mpc + 64'd4;
                    next_pc = (a + 64'($signed(inst[31:20]))) & ~64'd1;
                    if (inst[14:12] != 3'b000) millegal = 1'b1;
                end
                7'h37: begin
                    wr   = 1'b1;
                    wval = 64'($signed({inst[31:12], 12'h000}));
                end
                7'h17: begin
                    wr   = 1'b1;
                    wval = mpc + 64'($signed({inst[31:12], 12'h000}));
                end
                7'h73: begin
                    if (inst == EBREAK_WORD) mdone = 1'b1;
                    else millegal = 1'b1;
                end
                default: millegal = 1'b1;
            endcase
            if (!mdone && !millegal) begin
                if (wr && inst[11:7] != 5'd0) mregs[inst[11:7]] = wval;
                mpc = next_pc & 64'(IMEM_WORDS * 4 - 1);
            end
            steps++;
        end
        if (!mdone && !millegal) begin
            $display("reference model did not halt within %0d steps", MAX_STEPS);
            $display("Errors found");
            $fatal(1, "model");
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            write_ok(ADDR_IMEM_BASE + 12'(4 * i), prog[AW'(i)]);
        end
    endtask

    task automatic wait_halt();
        logic [31:0] st;
        int          polls;
        read_ok(ADDR_STATUS, st);
        polls = 1;
        while (st[2] && polls < MAX_POLLS) begin
            read_ok(ADDR_STATUS, st);
            polls++;
        end
        if (st[2]) begin
            $display("core still running after %0d status polls", polls);
            $display("Errors found");
            $fatal(1, "core did not halt");
        end
    endtask

    // status, pc and every register against the model
    task automatic check_state();
        logic [31:0] data;
        read_ok(ADDR_STATUS, data);
        check("status", 64'(data), 64'({1'b0, mdone, millegal}));
        read_ok(ADDR_PC, data);
        check("pc", 64'(data), 64'(mpc[31:0]));
        for (int i = 0; i < 32; i++) begin
            read_ok(ADDR_REG_BASE + 12'(8 * i), data);
            check($sformatf("x%0d low", i), 64'(data), 64'(mregs[5'(i)][31:0]));
            read_ok(ADDR_REG_BASE + 12'(8 * i + 4), data);
            check($sformatf("x%0d high", i), 64'(data), 64'(mregs[5'(i)][63:32]));
        end
    endtask

    task automatic run_program();
        model_run();
        load_program();
        write_ok(ADDR_CTRL, 32'h1);
        wait_halt();
        check_state();
    endtask

    task automatic reset_and_map_test();
        logic [31:0] data;
        logic        err;
        apb_write(ADDR_STATUS, 32'h1, err);
        check("pslverr status write", 64'(err), 64'd1);
        apb_write(ADDR_PC, 32'h4, err);
        check("pslverr pc write", 64'(err), 64'd1);
        apb_write(12'h300, 32'h5, err);
        check("pslverr unmapped write", 64'(err), 64'd1);
        apb_read(12'h10c, data, err);
        check("pslverr unmapped read", 64'(err), 64'd1);
        check("prdata unmapped read", 64'(data), 64'd0);
        apb_read(ADDR_IMEM_BASE, data, err);  // imem window is write only
        check("pslverr imem read", 64'(err), 64'd1);
        check_state();
    endtask

    task automatic arithmetic_test();
        logic [31:0] data;
        prog_len = 0;
        append_word(i_word(OP_IMM, 1, 0, 100));
        append_word(i_word(OP_IMM, 2, 0, -7));
        append_word(r_word(7'h00, 3, 1, 2));
        append_word(r_word(7'h20, 4, 2, 1));
        append_word(u_word(OP_LUI, 5, 'h80000));  // sign bit of the upper immediate
        append_word(u_word(OP_AUIPC, 6, 'h12345));
        append_word(i_word(OP_IMM, 0, 1, 5));
        append_word(r_word(7'h00, 0, 1, 1));
        append_word(r_word(7'h20, 7, 0, 5));
        append_word(EBREAK_WORD);
        run_program();
        read_ok(ADDR_PC, data);
        check("pc at ebreak", 64'(data), 64'(4 * (prog_len - 1)));
    endtask

    task automatic branch_loop_test();
        prog_len = 0;
        append_word(i_word(OP_IMM, 10, 0, 9));
        append_word(i_word(OP_IMM, 11, 0, 0));
        append_word(i_word(OP_IMM, 11, 11, 3));  // loop body at 8
        append_word(i_word(OP_IMM, 10, 10, -1));
        append_word(bne_word(10, 0, -8));
        append_word(EBREAK_WORD);
        run_program();
    endtask

    task automatic jump_test();
        prog_len = 0;
        append_word(i_word(OP_IMM, 1, 0, 1));
        append_word(jal_word(2, 12));
        append_word(i_word(OP_IMM, 1, 0, 99));
        append_word(i_word(OP_IMM, 3, 0, 99));
        append_word(i_word(OP_IMM, 5, 0, 25));
        append_word(i_word(OP_JALR, 6, 5, 8));  // 33 with bit 0 cleared
        append_word(i_word(OP_IMM, 1, 0, 77));
        append_word(i_word(OP_IMM, 4, 0, 77));
        append_word(r_word(7'h00, 7, 2, 6));
        append_word(EBREAK_WORD);
        run_program();
    endtask

    task automatic illegal_test();
        logic [31:0] data;
        logic        err;
        prog_len = 0;
        append_word(i_word(OP_IMM, 12, 0, 150));
        append_word(i_word(OP_IMM, 12, 12, -1));
        append_word(bne_word(12, 0, -4));
        append_word(i_word(OP_IMM, 8, 0, 123));
        append_word(i_word(OP_IMM, 9, 8, 1));
        append_word(ILLEGAL_WORD);
        append_word(i_word(OP_IMM, 8, 0, 0));
        model_run();
        load_program();
        write_ok(ADDR_CTRL, 32'h1);
        read_ok(ADDR_STATUS, data);
        check("status.running", 64'(data[2]), 64'd1);
        apb_write(ADDR_IMEM_BASE + 12'd20, EBREAK_WORD, err);  // try to patch the bad word
        check("pslverr imem write while running", 64'(err), 64'd1);
        wait_halt();
        check_state();
    endtask

    task automatic random_imm_test();
        int rnd;
        int rd;
        int rs1;
        for (int round = 0; round < 3; round++) begin
            prog_len = 0;
            for (int k = 0; k < 12; k++) begin
                rnd = $random(seed);
                rd  = 13 + k % 6;
                rs1 = (k == 0) ? 0 : 13 + (k + 5) % 6;  // previous destination
                append_word(i_word(OP_IMM, rd, rs1, rnd));
            end
            append_word(EBREAK_WORD);
            run_program();
        end
    endtask

    initial begin
        rst      = 1'b1;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        mpc      = '0;
        mdone    = 1'b0;
        millegal = 1'b0;
        prog_len = 0;
        for (int i = 0; i < 32; i++) begin
            mregs[5'(i)] = '0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        reset_and_map_test();
        arithmetic_test();
        branch_loop_test();
        jump_test();
        illegal_test();
        random_imm_test();
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: common/rvseed_pkg.sv
package rvseed_pkg;

    localparam int XLEN           = 64;
    localparam int INST_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int APB_ADDR_WIDTH = 12;
    localparam int APB_DATA_WIDTH = 32;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;  // add, sub, addi, jalr
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [6:0] F7_ADD     = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;
    localparam logic [INST_WIDTH-1:0] EBREAK_INST = 32'h0010_0073;

    typedef enum logic {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG     = 2'd0,  // rs1, rs2
        SRC_IMM     = 2'd1,  // rs1, imm
        SRC_IMM_PC  = 2'd2,  // pc, imm
        SRC_FOUR_PC = 2'd3   // pc, 4
    } alu_src_e;

    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_B = 2'd1,
        IMM_J = 2'd2,
        IMM_U = 2'd3
    } imm_op_e;

    typedef struct packed {
        logic                      branch;
        logic                      jump;
        logic                      jalr;
        logic                      reg_wen;
        logic [REG_ADDR_WIDTH-1:0] reg_waddr;
        logic [REG_ADDR_WIDTH-1:0] reg1_raddr;
        logic [REG_ADDR_WIDTH-1:0] reg2_raddr;
        imm_op_e                   imm_op;
        alu_op_e                   alu_op;
        alu_src_e                  alu_src;
    } ctrl_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_HALT = 2'd2
    } run_state_e;

    // read back at ADDR_STATUS bits 2:0
    typedef struct packed {
        logic running;
        logic done;     // ebreak reached
        logic illegal;
    } status_t;

    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_IMEM_BASE = 12'h000;
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_CTRL      = 12'h100;
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_STATUS    = 12'h104;
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_PC        = 12'h108;
    localparam logic [APB_ADDR_WIDTH-1:0] ADDR_REG_BASE  = 12'h200;

endpackage

// File: design/alu.sv
`timescale 1ns/1ps

module alu import rvseed_pkg::*; (
    input  ctrl_t           ctl,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;

    always_comb begin
        case (ctl.alu_src)
            SRC_REG:     begin op_a = rs1_data; op_b = rs2_data; end
            SRC_IMM:     begin op_a = rs1_data; op_b = imm;      end
            SRC_IMM_PC:  begin op_a = pc;       op_b = imm;      end
            SRC_FOUR_PC: begin op_a = pc;       op_b = XLEN'(4); end
            default:     begin op_a = rs1_data; op_b = rs2_data; end
        endcase
    end

    assign result = (ctl.alu_op == ALU_SUB) ? op_a - op_b : op_a + op_b;
    assign zero   = (result == '0);  // bne taken when low

endmodule

// File: design/apb_host.sv
`timescale 1ns/1ps

module apb_host import rvseed_pkg::*; #(
    parameter int IMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [APB_ADDR_WIDTH-1:0]     paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [APB_DATA_WIDTH-1:0]     pwdata,
    input  status_t                       status,
    input  logic [XLEN-1:0]               pc,
    input  logic [XLEN-1:0]               host_rdata,
    output logic [APB_DATA_WIDTH-1:0]     prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          imem_wen,
    output logic [$clog2(IMEM_WORDS)-1:0] imem_waddr,
    output logic [INST_WIDTH-1:0]         imem_wdata,
    output logic                          start,
    output logic [REG_ADDR_WIDTH-1:0]     host_raddr
);

    localparam int AW         = $clog2(IMEM_WORDS);
    localparam int IMEM_BYTES = IMEM_WORDS * 4;
    localparam int REG_BYTES  = (1 << REG_ADDR_WIDTH) * 8;  // two words per register

    logic                      setup_q;
    logic                      access;
    logic                      in_imem;
    logic                      in_regs;
    logic                      is_ctrl;
    logic                      is_status;
    logic                      is_pc;
    logic                      wr_ok;
    logic                      rd_ok;
    logic [APB_DATA_WIDTH-1:0] rd_mux;

    // access phase only counts after a setup cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= psel & ~penable;
        end
    end

    assign access = psel & penable & setup_q;

    assign in_imem   = (int'(paddr) < IMEM_BYTES) && (paddr < ADDR_CTRL);
    assign in_regs   = (paddr >= ADDR_REG_BASE) && (int'(paddr - ADDR_REG_BASE) < REG_BYTES);
    assign is_ctrl   = (paddr == ADDR_CTRL);
    assign is_status = (paddr == ADDR_STATUS);
    assign is_pc     = (paddr == ADDR_PC);

    assign wr_ok = (in_imem && !status.running) || is_ctrl;  // no imem writes while running
    assign rd_ok = is_status || is_pc || in_regs;

    assign imem_wen   = access & pwrite & in_imem & ~status.running;
    assign imem_waddr = paddr[AW+1:2];
    assign imem_wdata = pwdata;
    assign start      = access & pwrite & is_ctrl & pwdata[0];
    assign host_raddr = paddr[REG_ADDR_WIDTH+2:3];

    always_comb begin
        if (is_status) begin
            rd_mux = APB_DATA_WIDTH'(status);
        end else if (is_pc) begin
            rd_mux = pc[31:0];
        end else if (paddr[2]) begin
            rd_mux = host_rdata[63:32];  // high word of xi
        end else begin
            rd_mux = host_rdata[31:0];
        end
    end

    assign pready  = 1'b1;  // zero wait states
    assign pslverr = access & (pwrite ? ~wr_ok : ~rd_ok);
    assign prdata  = (access && !pwrite && rd_ok) ? rd_mux : '0;

endmodule

// File: design/ctrl.sv
`timescale 1ns/1ps

module ctrl import rvseed_pkg::*; (
    input  logic [INST_WIDTH-1:0] inst,
    output ctrl_t                 ctl,
    output logic                  illegal,
    output logic                  ebreak
);

    opcode_e                   opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [REG_ADDR_WIDTH-1:0] rs1;
    logic [REG_ADDR_WIDTH-1:0] rs2;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        ctl         = '0;
        ctl.imm_op  = IMM_I;
        ctl.alu_op  = ALU_ADD;
        ctl.alu_src = SRC_REG;
        illegal     = 1'b0;
        ebreak      = 1'b0;
        case (opcode)
            OP_R: begin
                ctl.reg_wen    = 1'b1;
                ctl.reg_waddr  = rd;
                ctl.reg1_raddr = rs1;
                ctl.reg2_raddr = rs2;
                ctl.alu_src    = SRC_REG;
                if (funct3 == F3_ADD_SUB && funct7 == F7_ADD) begin
                    ctl.alu_op = ALU_ADD;
                end else if (funct3 == F3_ADD_SUB && funct7 == F7_SUB) begin
                    ctl.alu_op = ALU_SUB;
                end else begin
                    illegal = 1'b1;
                end
            end
            OP_IMM: begin
                ctl.reg_wen    = 1'b1;
                ctl.reg_waddr  = rd;
                ctl.reg1_raddr = rs1;
                ctl.imm_op     = IMM_I;
                ctl.alu_src    = SRC_IMM;
                if (funct3 != F3_ADD_SUB) illegal = 1'b1;  // addi only
            end
            OP_BRANCH: begin
                ctl.reg1_raddr = rs1;
                ctl.reg2_raddr = rs2;
                ctl.imm_op     = IMM_B;
                ctl.alu_op     = ALU_SUB;  // zero result means equal
                ctl.alu_src    = SRC_REG;
                if (funct3 == F3_BNE) begin
                    ctl.branch = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            OP_JAL: begin
                ctl.jump      = 1'b1;
                ctl.reg_wen   = 1'b1;
                ctl.reg_waddr = rd;
                ctl.imm_op    = IMM_J;
                ctl.alu_src   = SRC_FOUR_PC;  // link value
            end
            OP_JALR: begin
                ctl.reg1_raddr = rs1;
                ctl.imm_op     = IMM_I;
                ctl.alu_src    = SRC_FOUR_PC;
                if (funct3 == F3_ADD_SUB) begin
                    ctl.jump      = 1'b1;
                    ctl.jalr      = 1'b1;
                    ctl.reg_wen   = 1'b1;
                    ctl.reg_waddr = rd;
                end else begin
                    illegal = 1'b1;
                end
            end
            OP_LUI: begin
                ctl.reg_wen    = 1'b1;
                ctl.reg_waddr  = rd;
                ctl.reg1_raddr = '0;  // x0 + imm
                ctl.imm_op     = IMM_U;
                ctl.alu_src    = SRC_IMM;
            end
            OP_AUIPC: begin
                ctl.reg_wen   = 1'b1;
                ctl.reg_waddr = rd;
                ctl.imm_op    = IMM_U;
                ctl.alu_src   = SRC_IMM_PC;
            end
            OP_SYSTEM: begin
                if (inst == EBREAK_INST) begin
                    ebreak = 1'b1;
                end else begin
                    illegal = 1'b1;  // no csr or ecall support
                end
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

// File: design/imem.sv
`timescale 1ns/1ps

module imem import rvseed_pkg::*; #(
    parameter int IMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          wen,
    input  logic [$clog2(IMEM_WORDS)-1:0] waddr,
    input  logic [INST_WIDTH-1:0]         wdata,
    input  logic [XLEN-1:0]               pc,
    output logic [INST_WIDTH-1:0]         inst
);

    localparam int AW = $clog2(IMEM_WORDS);

    logic [INST_WIDTH-1:0] mem [IMEM_WORDS];

    always_ff @(posedge clk) begin
        if (wen) mem[waddr] <= wdata;  // host load port
    end

    assign inst = mem[pc[AW+1:2]];  // word index from byte pc

endmodule

// File: design/imm_gen.sv
`timescale 1ns/1ps

module imm_gen import rvseed_pkg::*; (
    input  logic [INST_WIDTH-1:0] inst,
    input  imm_op_e               imm_op,
    output logic [XLEN-1:0]       imm
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_u;

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};  // already shifted by 12

    always_comb begin
        case (imm_op)
            IMM_I:   imm = imm_i;
            IMM_B:   imm = imm_b;
            IMM_J:   imm = imm_j;
            IMM_U:   imm = imm_u;
            default: imm = imm_i;
        endcase
    end

endmodule

// File: design/pc_unit.sv
`timescale 1ns/1ps

module pc_unit import rvseed_pkg::*; #(
    parameter int IMEM_WORDS = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  ctrl_t           ctl,
    input  logic            illegal,
    input  logic            ebreak,
    input  logic            zero,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] pc,
    output logic            wb_en,
    output status_t         status
);

    localparam int PC_BITS = $clog2(IMEM_WORDS) + 2;  // byte address bits of imem

    run_state_e      state;
    logic            done_q;
    logic            illegal_q;
    logic            running;
    logic            halt;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] pc_next;

    assign running  = (state == ST_RUN);
    assign halt     = illegal | ebreak;
    assign wb_en    = running & ctl.reg_wen & ~halt;
    assign jalr_sum = rs1_data + imm;

    always_comb begin
        if (ctl.jalr) begin
            target = {jalr_sum[XLEN-1:1], 1'b0};
        end else if (ctl.jump || (ctl.branch && !zero)) begin
            target = pc + imm;
        end else begin
            target = pc + XLEN'(4);
        end
    end

    assign pc_next = XLEN'(target[PC_BITS-1:0]);  // wrap inside imem

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            pc        <= '0;
            done_q    <= 1'b0;
            illegal_q <= 1'b0;
        end else if (start) begin
            state     <= ST_RUN;
            pc        <= '0;
            done_q    <= 1'b0;
            illegal_q <= 1'b0;
        end else if (running) begin
            if (halt) begin
                state     <= ST_HALT;  // pc keeps the halting instruction
                done_q    <= ebreak;
                illegal_q <= illegal;
            end else begin
                pc <= pc_next;
            end
        end
    end

    assign status.running = running;
    assign status.done    = done_q;
    assign status.illegal = illegal_q;

endmodule

// File: design/regfile.sv
`timescale 1ns/1ps

module regfile import rvseed_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [REG_ADDR_WIDTH-1:0] raddr1,
    input  logic [REG_ADDR_WIDTH-1:0] raddr2,
    input  logic [REG_ADDR_WIDTH-1:0] host_raddr,
    input  logic                      wen,
    input  logic [REG_ADDR_WIDTH-1:0] waddr,
    input  logic [XLEN-1:0]           wdata,
    output logic [XLEN-1:0]           rdata1,
    output logic [XLEN-1:0]           rdata2,
    output logic [XLEN-1:0]           host_rdata
);

    localparam int NUM_REGS = 1 << REG_ADDR_WIDTH;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin  // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    // async reads, no write bypass needed in a single-cycle core
    assign rdata1     = regs[raddr1];
    assign rdata2     = regs[raddr2];
    assign host_rdata = regs[host_raddr];

endmodule

// File: design/rvseed_top.sv
`timescale 1ns/1ps

module rvseed_top import rvseed_pkg::*; #(
    parameter int IMEM_WORDS = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [APB_DATA_WIDTH-1:0] pwdata,
    output logic [APB_DATA_WIDTH-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr
);

    logic                          imem_wen;
    logic [$clog2(IMEM_WORDS)-1:0] imem_waddr;
    logic [INST_WIDTH-1:0]         imem_wdata;
    logic                          start;
    logic [REG_ADDR_WIDTH-1:0]     host_raddr;
    logic [XLEN-1:0]               host_rdata;
    logic [INST_WIDTH-1:0]         inst;
    ctrl_t                         ctl;
    logic                          illegal;
    logic                          ebreak;
    logic [XLEN-1:0]               imm;
    logic [XLEN-1:0]               rs1_data;
    logic [XLEN-1:0]               rs2_data;
    logic [XLEN-1:0]               result;
    logic                          zero;
    logic [XLEN-1:0]               pc;
    logic                          wb_en;
    status_t                       status;

    apb_host #(.IMEM_WORDS(IMEM_WORDS)) apb_host_inst (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .status(status), .pc(pc),
        .host_rdata(host_rdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .imem_wen(imem_wen), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata),
        .start(start), .host_raddr(host_raddr)
    );

    imem #(.IMEM_WORDS(IMEM_WORDS)) imem_inst (
        .clk(clk), .wen(imem_wen), .waddr(imem_waddr), .wdata(imem_wdata),
        .pc(pc), .inst(inst)
    );

    ctrl ctrl_inst (.inst(inst), .ctl(ctl), .illegal(illegal), .ebreak(ebreak));

    imm_gen imm_gen_inst (.inst(inst), .imm_op(ctl.imm_op), .imm(imm));

    regfile regfile_inst (
        .clk(clk), .rst(rst), .raddr1(ctl.reg1_raddr), .raddr2(ctl.reg2_raddr),
        .host_raddr(host_raddr), .wen(wb_en), .waddr(ctl.reg_waddr), .wdata(result),
        .rdata1(rs1_data), .rdata2(rs2_data), .host_rdata(host_rdata)
    );

    alu alu_inst (
        .ctl(ctl), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .pc(pc),
        .result(result), .zero(zero)
    );

    pc_unit #(.IMEM_WORDS(IMEM_WORDS)) pc_unit_inst (
        .clk(clk), .rst(rst), .start(start), .ctl(ctl), .illegal(illegal),
        .ebreak(ebreak), .zero(zero), .imm(imm), .rs1_data(rs1_data),
        .pc(pc), .wb_en(wb_en), .status(status)
    );

endmodule

// File: filelist.f
common/rvseed_pkg.sv
design/ctrl.sv
design/imm_gen.sv
design/alu.sv
design/regfile.sv
design/pc_unit.sv
design/imem.sv
design/apb_host.sv
design/rvseed_top.sv
bench/tb_rvseed.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the rvseed testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_rvseed -f filelist.f -o tb_rvseed_sim

if ./obj_dir/tb_rvseed_sim | tee /dev/stderr | grep -x "No errors" > /dev/null; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
